/* stat_pkg.sv */
// ==================================================================
// Event statistics package: sizes, timing, AXI4-Lite register map
// offsets and the 64-bit counter word union.
// ==================================================================
`default_nettype none

package stat_pkg;

    localparam int STAT_COUNT         = 8;    // event channels.
    localparam int STAT_INC_WIDTH     = 8;    // per-cycle increment of one channel.
    localparam int STAT_ID_WIDTH      = 3;    // channel id in a flush word.
    localparam int STAT_STREAM_WIDTH  = 16;   // increment carried by a flush word.
    localparam int STAT_UPDATE_PERIOD = 64;   // cycles between automatic flushes.

    // one scheduler round of 2*STAT_COUNT cycles must fit in the accumulator
    localparam int STAT_ACC_WIDTH     = STAT_INC_WIDTH + STAT_ID_WIDTH + 1;
    localparam int STAT_PERIOD_WIDTH  = $clog2(STAT_UPDATE_PERIOD);

    localparam int STAT_CNT_WIDTH     = 64;   // counter width.
    localparam int AXIL_ADDR_WIDTH    = 8;
    localparam int AXIL_DATA_WIDTH    = 32;

    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL     = 8'h00;  // bit 0 requests a flush.
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CNT_BASE = 8'h40;  // lo at +8n, hi at +8n+4.

    // counter word, added as one number and moved over the bus as halves
    typedef union packed {
        logic [STAT_CNT_WIDTH-1:0] full;
        struct packed {
            logic [AXIL_DATA_WIDTH-1:0] hi;
            logic [AXIL_DATA_WIDTH-1:0] lo;
        } half;
    } stat_cnt_u;

endpackage

`default_nettype wire

/* stat_collect.sv */
// ==================================================================
// Statistics collector: per-channel accumulators, a partial-sum
// memory and a two-phase scheduler that emits flush words.
// ==================================================================
`timescale 1ns/1ps
`default_nettype none

module stat_collect (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [stat_pkg::STAT_COUNT*stat_pkg::STAT_INC_WIDTH-1:0] stat_inc,
    input  logic [stat_pkg::STAT_COUNT-1:0]                          stat_valid,
    input  logic                                                    flush_req,
    output logic [stat_pkg::STAT_STREAM_WIDTH-1:0]                   flush_data,
    output logic [stat_pkg::STAT_ID_WIDTH-1:0]                       flush_id,
    output logic                                                    flush_valid,
    input  logic                                                    flush_ready
);
    import stat_pkg::*;

    logic                          phase;         // 0 reads memory, 1 writes it.
    logic [STAT_ID_WIDTH-1:0]      count;         // channel being visited.
    logic [STAT_PERIOD_WIDTH-1:0]  period;        // cycles to next automatic flush.
    logic [STAT_COUNT-1:0]         zero;          // memory entry not written yet.
    logic [STAT_COUNT-1:0]         update;        // channel marked for flush.
    logic [STAT_COUNT-1:0]         acc_clear;
    logic [STAT_ACC_WIDTH-1:0]     acc [STAT_COUNT];
    logic [STAT_STREAM_WIDTH-1:0]  mem [STAT_COUNT];
    logic [STAT_STREAM_WIDTH-1:0]  mem_rd_data;
    logic [STAT_STREAM_WIDTH-1:0]  part_sum;
    logic                          emit;

    // memory holds garbage until the first pass has written each entry
    assign part_sum = (zero[count] ? '0 : mem_rd_data) + STAT_STREAM_WIDTH'(acc[count]);
    assign emit     = phase && update[count] && (!flush_valid || flush_ready);

    always_comb begin
        acc_clear        = '0;
        acc_clear[count] = phase;               // fold and clear in the write phase.
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < STAT_COUNT; i++) begin
            if (rst) begin
                acc[i] <= '0;
            end else if (acc_clear[i]) begin
                // a same-cycle increment starts the fresh sum
                acc[i] <= stat_valid[i] ?
                          STAT_ACC_WIDTH'(stat_inc[i*STAT_INC_WIDTH +: STAT_INC_WIDTH]) : '0;
            end else if (stat_valid[i]) begin
                acc[i] <= acc[i] + STAT_ACC_WIDTH'(stat_inc[i*STAT_INC_WIDTH +: STAT_INC_WIDTH]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= 1'b0;
            count       <= '0;
            period      <= STAT_PERIOD_WIDTH'(STAT_UPDATE_PERIOD - 1);
            zero        <= '1;
            update      <= '0;
            flush_valid <= 1'b0;
        end else begin
            phase <= !phase;
            if (phase) begin
                zero[count] <= 1'b0;
                if (count == STAT_ID_WIDTH'(STAT_COUNT - 1)) begin
                    count <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end

            if (flush_ready) begin
                flush_valid <= 1'b0;            // word taken by the bank.
            end
            if (emit) begin
                update[count] <= 1'b0;
                flush_valid   <= part_sum != '0;
            end

            if (period == '0) begin
                period <= STAT_PERIOD_WIDTH'(STAT_UPDATE_PERIOD - 1);
                update <= '1;
            end else begin
                period <= period - 1'b1;
            end
            if (flush_req) begin
                update <= '1;                   // software flush marks every channel.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase) begin
            mem[count] <= emit ? '0 : part_sum; // emitted sums restart from zero.
        end else begin
            mem_rd_data <= mem[count];
        end
        if (emit) begin
            flush_data <= part_sum;
            flush_id   <= count;
        end
    end

endmodule

`default_nettype wire

/* stat_counter_bank.sv */
// ==================================================================
// Counter bank: single-port memory of 64-bit counters with a
// read-add-write pipeline for flush words and a software port.
// ==================================================================
`timescale 1ns/1ps
`default_nettype none

module stat_counter_bank (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [stat_pkg::STAT_STREAM_WIDTH-1:0] flush_data,
    input  logic [stat_pkg::STAT_ID_WIDTH-1:0]     flush_id,
    input  logic                                  flush_valid,
    output logic                                  flush_ready,
    input  logic                                  acc_en,
    input  logic                                  acc_we,
    input  logic [stat_pkg::STAT_ID_WIDTH-1:0]     acc_id,
    input  stat_pkg::stat_cnt_u                    acc_wdata,
    output stat_pkg::stat_cnt_u                    acc_rdata
);
    import stat_pkg::*;

    logic [STAT_CNT_WIDTH-1:0]     mem [STAT_COUNT];
    logic                          rd_valid;    // word waiting for its read slot.
    logic                          wr_valid;    // word waiting for its write slot.
    logic [STAT_ID_WIDTH-1:0]      rd_id;
    logic [STAT_ID_WIDTH-1:0]      wr_id;
    logic [STAT_STREAM_WIDTH-1:0]  rd_inc;
    logic [STAT_STREAM_WIDTH-1:0]  wr_inc;
    stat_cnt_u                     wr_base;     // counter value the increment adds to.
    logic                          accept;
    logic                          rd_go;
    logic                          wr_go;

    // one memory access per cycle, software first, then write, then read
    assign flush_ready = !acc_en && !rd_valid;
    assign accept      = flush_valid && flush_ready;
    assign wr_go       = wr_valid && !acc_en;
    assign rd_go       = rd_valid && !acc_en && !wr_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            if (accept) begin
                rd_valid <= 1'b1;
            end else if (rd_go) begin
                rd_valid <= 1'b0;
            end
            if (rd_go) begin
                wr_valid <= 1'b1;
            end else if (wr_go) begin
                wr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_id  <= flush_id;
            rd_inc <= flush_data;
        end
        if (rd_go) begin
            wr_id  <= rd_id;
            wr_inc <= rd_inc;
        end

        if (acc_en) begin
            acc_rdata.full <= mem[acc_id];
            if (acc_we) begin
                mem[acc_id] <= acc_wdata.full;
            end
            // a preset overtakes a word already read, so forward it
            if (acc_we && wr_valid && acc_id == wr_id) begin
                wr_base <= acc_wdata;
            end
        end else if (wr_go) begin
            mem[wr_id] <= wr_base.full + STAT_CNT_WIDTH'(wr_inc);
        end else if (rd_go) begin
            wr_base.full <= mem[rd_id];
        end
    end

endmodule

`default_nettype wire

/* stat_axil_regs.sv */
// ==================================================================
// AXI4-Lite register slave: counter read with hi snapshot, counter
// preset through a lo shadow, and the software flush request.
// ==================================================================
`timescale 1ns/1ps
`default_nettype none

module stat_axil_regs (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [stat_pkg::AXIL_ADDR_WIDTH-1:0]     s_axil_awaddr,
    input  logic                                    s_axil_awvalid,
    output logic                                    s_axil_awready,
    input  logic [stat_pkg::AXIL_DATA_WIDTH-1:0]     s_axil_wdata,
    input  logic [stat_pkg::AXIL_DATA_WIDTH/8-1:0]   s_axil_wstrb,
    input  logic                                    s_axil_wvalid,
    output logic                                    s_axil_wready,
    output logic [1:0]                              s_axil_bresp,
    output logic                                    s_axil_bvalid,
    input  logic                                    s_axil_bready,
    input  logic [stat_pkg::AXIL_ADDR_WIDTH-1:0]     s_axil_araddr,
    input  logic                                    s_axil_arvalid,
    output logic                                    s_axil_arready,
    output logic [stat_pkg::AXIL_DATA_WIDTH-1:0]     s_axil_rdata,
    output logic [1:0]                              s_axil_rresp,
    output logic                                    s_axil_rvalid,
    input  logic                                    s_axil_rready,
    output logic                                    flush_req,
    output logic                                    acc_en,
    output logic                                    acc_we,
    output logic [stat_pkg::STAT_ID_WIDTH-1:0]       acc_id,
    output stat_pkg::stat_cnt_u                      acc_wdata,
    input  stat_pkg::stat_cnt_u                      acc_rdata
);
    import stat_pkg::*;

    logic [AXIL_ADDR_WIDTH-1:0]    w_addr;
    logic [AXIL_ADDR_WIDTH-1:0]    r_addr;
    logic [AXIL_DATA_WIDTH-1:0]    w_data;
    logic [AXIL_DATA_WIDTH/8-1:0]  w_strb;
    logic [AXIL_DATA_WIDTH-1:0]    preset_lo;   // lo half waiting for its hi write.
    logic [AXIL_DATA_WIDTH-1:0]    snap_hi;     // hi half taken with the last lo read.
    logic [STAT_ID_WIDTH-1:0]      snap_id;
    logic                          snap_valid;
    logic                          rd_issue;    // counter fetch cycle.
    logic                          rd_resp;     // fetched data is on acc_rdata.
    logic                          aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic                          wr_exec;
    logic                          w_is_ctrl, w_is_cnt, w_full;
    logic                          r_is_cnt, r_snap_hit, r_fetch;

    assign s_axil_bresp = 2'b00;
    assign s_axil_rresp = 2'b00;

    assign aw_hs = s_axil_awvalid && s_axil_awready;
    assign w_hs  = s_axil_wvalid && s_axil_wready;
    assign b_hs  = s_axil_bvalid && s_axil_bready;
    assign ar_hs = s_axil_arvalid && s_axil_arready;
    assign r_hs  = s_axil_rvalid && s_axil_rready;

    assign w_is_ctrl  = w_addr[AXIL_ADDR_WIDTH-1:2] == REG_CTRL[AXIL_ADDR_WIDTH-1:2];
    assign w_is_cnt   = w_addr[AXIL_ADDR_WIDTH-1:STAT_ID_WIDTH+3] ==
                        REG_CNT_BASE[AXIL_ADDR_WIDTH-1:STAT_ID_WIDTH+3];
    assign w_full     = &w_strb;                // counter halves need every byte.
    assign r_is_cnt   = r_addr[AXIL_ADDR_WIDTH-1:STAT_ID_WIDTH+3] ==
                        REG_CNT_BASE[AXIL_ADDR_WIDTH-1:STAT_ID_WIDTH+3];
    assign r_snap_hit = snap_valid && snap_id == r_addr[3 +: STAT_ID_WIDTH];
    assign r_fetch    = r_is_cnt && !(r_addr[2] && r_snap_hit);

    // both halves of a write are in, and a pending read goes first
    assign wr_exec = !s_axil_awready && !s_axil_wready && !s_axil_bvalid &&
                     s_axil_arready && !s_axil_arvalid;

    assign flush_req = wr_exec && w_is_ctrl && w_strb[0] && w_data[0];
    assign acc_en    = (rd_issue && r_fetch) || (wr_exec && w_is_cnt && w_addr[2] && w_full);
    assign acc_we    = wr_exec;
    assign acc_id    = wr_exec ? w_addr[3 +: STAT_ID_WIDTH] : r_addr[3 +: STAT_ID_WIDTH];

    always_comb begin
        acc_wdata.half.hi = w_data;
        acc_wdata.half.lo = preset_lo;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_axil_awready <= 1'b1;
            s_axil_wready  <= 1'b1;
            s_axil_arready <= 1'b1;
            s_axil_bvalid  <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            rd_issue       <= 1'b0;
            rd_resp        <= 1'b0;
            snap_valid     <= 1'b0;
        end else begin
            rd_issue <= ar_hs;
            rd_resp  <= rd_issue;
            if (aw_hs) begin
                s_axil_awready <= 1'b0;
            end
            if (w_hs) begin
                s_axil_wready <= 1'b0;
            end
            if (ar_hs || wr_exec) begin
                s_axil_arready <= 1'b0;         // one access at a time.
            end
            if (wr_exec) begin
                s_axil_bvalid <= 1'b1;
            end
            if (b_hs) begin
                s_axil_bvalid  <= 1'b0;
                s_axil_awready <= 1'b1;
                s_axil_wready  <= 1'b1;
                s_axil_arready <= 1'b1;
            end
            if (rd_resp) begin
                s_axil_rvalid <= 1'b1;
                if (r_is_cnt && !r_addr[2]) begin
                    snap_valid <= 1'b1;
                end else if (r_addr[2] && r_snap_hit) begin
                    snap_valid <= 1'b0;         // snapshot used by its hi read.
                end
            end
            if (r_hs) begin
                s_axil_rvalid  <= 1'b0;
                s_axil_arready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            w_addr <= s_axil_awaddr;
        end
        if (w_hs) begin
            w_data <= s_axil_wdata;
            w_strb <= s_axil_wstrb;
        end
        if (ar_hs) begin
            r_addr <= s_axil_araddr;
        end
        if (wr_exec && w_is_cnt && !w_addr[2] && w_full) begin
            preset_lo <= w_data;
        end
        if (rd_resp) begin
            if (!r_is_cnt) begin
                s_axil_rdata <= '0;             // control and unmapped read zero.
            end else if (!r_addr[2]) begin
                s_axil_rdata <= acc_rdata.half.lo;
                snap_hi      <= acc_rdata.half.hi;
                snap_id      <= r_addr[3 +: STAT_ID_WIDTH];
            end else if (r_fetch) begin
                s_axil_rdata <= acc_rdata.half.hi;
            end else begin
                s_axil_rdata <= snap_hi;
            end
        end
    end

endmodule

`default_nettype wire

/* stat_top.sv */
// ==================================================================
// Event statistics top level: collector, counter bank and
// AXI4-Lite register slave.
// ==================================================================
`timescale 1ns/1ps
`default_nettype none

module stat_top (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [stat_pkg::STAT_COUNT*stat_pkg::STAT_INC_WIDTH-1:0] stat_inc,
    input  logic [stat_pkg::STAT_COUNT-1:0]                          stat_valid,
    input  logic [stat_pkg::AXIL_ADDR_WIDTH-1:0]                     s_axil_awaddr,
    input  logic                                                    s_axil_awvalid,
    output logic                                                    s_axil_awready,
    input  logic [stat_pkg::AXIL_DATA_WIDTH-1:0]                     s_axil_wdata,
    input  logic [stat_pkg::AXIL_DATA_WIDTH/8-1:0]                   s_axil_wstrb,
    input  logic                                                    s_axil_wvalid,
    output logic                                                    s_axil_wready,
    output logic [1:0]                                              s_axil_bresp,
    output logic                                                    s_axil_bvalid,
    input  logic                                                    s_axil_bready,
    input  logic [stat_pkg::AXIL_ADDR_WIDTH-1:0]                     s_axil_araddr,
    input  logic                                                    s_axil_arvalid,
    output logic                                                    s_axil_arready,
    output logic [stat_pkg::AXIL_DATA_WIDTH-1:0]                     s_axil_rdata,
    output logic [1:0]                                              s_axil_rresp,
    output logic                                                    s_axil_rvalid,
    input  logic                                                    s_axil_rready
);
    import stat_pkg::*;

    logic [STAT_STREAM_WIDTH-1:0]  flush_data;
    logic [STAT_ID_WIDTH-1:0]      flush_id;
    logic                          flush_valid;
    logic                          flush_ready;
    logic                          flush_req;  // software flush pulse.
    logic                          acc_en;
    logic                          acc_we;
    logic [STAT_ID_WIDTH-1:0]      acc_id;
    stat_cnt_u                     acc_wdata;
    stat_cnt_u                     acc_rdata;

    stat_collect stat_collect_i (
        .clk         (clk),
        .rst         (rst),
        .stat_inc    (stat_inc),
        .stat_valid  (stat_valid),
        .flush_req   (flush_req),
        .flush_data  (flush_data),
        .flush_id    (flush_id),
        .flush_valid (flush_valid),
        .flush_ready (flush_ready)
    );

    stat_counter_bank stat_counter_bank_i (
        .clk         (clk),
        .rst         (rst),
        .flush_data  (flush_data),
        .flush_id    (flush_id),
        .flush_valid (flush_valid),
        .flush_ready (flush_ready),
        .acc_en      (acc_en),
        .acc_we      (acc_we),
        .acc_id      (acc_id),
        .acc_wdata   (acc_wdata),
        .acc_rdata   (acc_rdata)
    );

    stat_axil_regs stat_axil_regs_i (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .flush_req      (flush_req),
        .acc_en         (acc_en),
        .acc_we         (acc_we),
        .acc_id         (acc_id),
        .acc_wdata      (acc_wdata),
        .acc_rdata      (acc_rdata)
    );

endmodule

`default_nettype wire

/* stat_tb.sv */
// ==================================================================
// Testbench for the event statistics block: AXI4-Lite master tasks,
// a table of stimulus rows, a per-channel reference model and checks.
// ==================================================================
`timescale 1ns/1ps
`default_nettype none

module stat_tb;
    import stat_pkg::*;

    localparam int WAIT_LIMIT  = 200;                             // cycles per handshake wait.
    localparam int DRAIN_IDLE  = 2 * STAT_COUNT * 2 + 4 + 16;     // collector drain plus bank.
    localparam int PERIOD_IDLE = STAT_UPDATE_PERIOD + DRAIN_IDLE;
    localparam int ROWS        = 6;

    typedef struct packed {
        logic [STAT_COUNT-1:0]     mask;        // channels driven in this row.
        logic                      rand_inc;
        logic [STAT_INC_WIDTH-1:0] inc;
        logic [15:0]               cycles;
        logic                      flush;       // flush by a REG_CTRL write.
        logic                      bus_load;    // counter reads during stimulus.
        logic                      preset;
        logic [STAT_CNT_WIDTH-1:0] preset_val;
    } row_t;

    logic                                   clk;
    logic                                   rst;
    logic [STAT_COUNT*STAT_INC_WIDTH-1:0]   stat_inc;
    logic [STAT_COUNT-1:0]                  stat_valid;
    logic [AXIL_ADDR_WIDTH-1:0]             s_axil_awaddr;
    logic                                   s_axil_awvalid;
    logic                                   s_axil_awready;
    logic [AXIL_DATA_WIDTH-1:0]             s_axil_wdata;
    logic [AXIL_DATA_WIDTH/8-1:0]           s_axil_wstrb;
    logic                                   s_axil_wvalid;
    logic                                   s_axil_wready;
    logic [1:0]                             s_axil_bresp;
    logic                                   s_axil_bvalid;
    logic                                   s_axil_bready;
    logic [AXIL_ADDR_WIDTH-1:0]             s_axil_araddr;
    logic                                   s_axil_arvalid;
    logic                                   s_axil_arready;
    logic [AXIL_DATA_WIDTH-1:0]             s_axil_rdata;
    logic [1:0]                             s_axil_rresp;
    logic                                   s_axil_rvalid;
    logic                                   s_axil_rready;

    logic [STAT_CNT_WIDTH-1:0]              model_total [STAT_COUNT];   // expected counters.
    row_t                                   rows [ROWS];

    stat_top stat_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected 0x%h actual 0x%h", name, expected, actual);
            stop_run();
        end
    endtask

    function automatic logic [AXIL_ADDR_WIDTH-1:0] lo_addr(input int ch);
        return AXIL_ADDR_WIDTH'(REG_CNT_BASE + 8 * ch);
    endfunction

    function automatic logic [AXIL_ADDR_WIDTH-1:0] hi_addr(input int ch);
        return AXIL_ADDR_WIDTH'(REG_CNT_BASE + 8 * ch + 4);
    endfunction

    function automatic row_t make_row(input logic [7:0] mask, input logic rand_inc,
                                      input logic [7:0] inc, input int cycles,
                                      input logic flush, input logic bus_load,
                                      input logic preset, input logic [63:0] preset_val);
        row_t r;
        r.mask       = mask;
        r.rand_inc   = rand_inc;
        r.inc        = inc;
        r.cycles     = 16'(cycles);
        r.flush      = flush;
        r.bus_load   = bus_load;
        r.preset     = preset;
        r.preset_val = preset_val;
        return r;
    endfunction

    task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                              input logic [AXIL_DATA_WIDTH-1:0] data);
        int waited;
        bit aw_done;
        bit w_done;
        @(posedge clk);
        s_axil_awaddr  <= addr;
        s_axil_awvalid <= 1'b1;
        s_axil_wdata   <= data;
        s_axil_wstrb   <= '1;
        s_axil_wvalid  <= 1'b1;
        aw_done = 1'b0;
        w_done  = 1'b0;
        waited  = 0;
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            waited++;
            if (!aw_done && s_axil_awready) begin
                aw_done = 1'b1;
                s_axil_awvalid <= 1'b0;
            end
            if (!w_done && s_axil_wready) begin
                w_done = 1'b1;
                s_axil_wvalid <= 1'b0;
            end
            if (waited > WAIT_LIMIT) begin
                $display("timeout: write address or data channel stalled at 0x%h", addr);
                stop_run();
            end
        end
        s_axil_bready <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: write response channel stalled at 0x%h", addr);
                stop_run();
            end
        end while (!s_axil_bvalid);
        s_axil_bready <= 1'b0;
        check_value($sformatf("bresp at 0x%h", addr), 64'd0, s_axil_bresp);
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                             output logic [AXIL_DATA_WIDTH-1:0] data);
        int waited;
        @(posedge clk);
        s_axil_araddr  <= addr;
        s_axil_arvalid <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: read address channel stalled at 0x%h", addr);
                stop_run();
            end
        end while (!s_axil_arready);
        s_axil_arvalid <= 1'b0;
        s_axil_rready  <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: read data channel stalled at 0x%h", addr);
                stop_run();
            end
        end while (!s_axil_rvalid);
        s_axil_rready <= 1'b0;
        data = s_axil_rdata;                     // sampled at the handshake edge.
        check_value($sformatf("rresp at 0x%h", addr), 64'd0, s_axil_rresp);
    endtask

    task automatic preset_counter(input int ch, input logic [63:0] value);
        axil_write(lo_addr(ch), value[31:0]);
        axil_write(hi_addr(ch), value[63:32]);   // hi write commits both halves.
        model_total[ch] = value;
    endtask

    task automatic check_counters(input string tag);
        logic [AXIL_DATA_WIDTH-1:0] lo;
        logic [AXIL_DATA_WIDTH-1:0] hi;
        for (int ch = 0; ch < STAT_COUNT; ch++) begin
            axil_read(lo_addr(ch), lo);
            axil_read(hi_addr(ch), hi);
            check_value($sformatf("%s ch%0d", tag, ch), model_total[ch], {hi, lo});
        end
    endtask

    // counter reads that steal memory cycles from the flush stream
    task automatic load_bus(input int reads);
        logic [AXIL_DATA_WIDTH-1:0] data;
        int                         ch;
        repeat (reads) begin
            ch = int'($urandom % STAT_COUNT);
            axil_read(lo_addr(ch), data);
            axil_read(hi_addr(ch), data);
        end
    endtask

    task automatic drive_row(input row_t row);
        logic [STAT_COUNT*STAT_INC_WIDTH-1:0] inc_bus;
        logic [STAT_COUNT-1:0]                valid;
        logic [STAT_INC_WIDTH-1:0]            inc;
        for (int c = 0; c < row.cycles; c++) begin
            @(posedge clk);
            valid = row.rand_inc ? (row.mask & STAT_COUNT'($urandom)) : row.mask;
            for (int ch = 0; ch < STAT_COUNT; ch++) begin
                inc = row.rand_inc ? STAT_INC_WIDTH'($urandom % 256) : row.inc;
                inc_bus[ch*STAT_INC_WIDTH +: STAT_INC_WIDTH] = inc;
                if (valid[ch]) begin
                    model_total[ch] += STAT_CNT_WIDTH'(inc);
                end
            end
            stat_inc   <= inc_bus;
            stat_valid <= valid;
        end
        @(posedge clk);
        stat_inc   <= '0;
        stat_valid <= '0;
    endtask

    initial begin
        logic [AXIL_DATA_WIDTH-1:0] lo;
        logic [AXIL_DATA_WIDTH-1:0] hi;
        void'($urandom(9));
        rst            = 1'b1;
        stat_inc       = '0;
        stat_valid     = '0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;

        rows[0] = make_row(8'h01, 1'b0, 8'd5,   20,  1'b1, 1'b0, 1'b0, 64'd0);
        rows[1] = make_row(8'hA5, 1'b0, 8'd255, 16,  1'b1, 1'b0, 1'b0, 64'd0);
        rows[2] = make_row(8'h3C, 1'b0, 8'd1,   40,  1'b1, 1'b0, 1'b0, 64'd0);
        rows[3] = make_row(8'hFF, 1'b1, 8'd0,   200, 1'b1, 1'b1, 1'b0, 64'd0);
        rows[4] = make_row(8'h42, 1'b0, 8'd7,   30,  1'b0, 1'b0, 1'b0, 64'd0);
        rows[5] = make_row(8'h20, 1'b0, 8'd100, 3,   1'b1, 1'b0, 1'b1, 64'hFFFF_FF00);

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // counters come up unknown, so clear them from software
        for (int ch = 0; ch < STAT_COUNT; ch++) begin
            preset_counter(ch, 64'd0);
        end
        check_counters("after reset");
        axil_read(REG_CTRL, lo);
        check_value("ctrl read", 64'd0, lo);
        axil_read(8'h10, lo);
        check_value("unmapped read 0x10", 64'd0, lo);
        axil_read(8'hA4, lo);
        check_value("unmapped read 0xA4", 64'd0, lo);

        for (int r = 0; r < ROWS; r++) begin
            if (rows[r].preset) begin
                for (int ch = 0; ch < STAT_COUNT; ch++) begin
                    if (rows[r].mask[ch]) begin
                        preset_counter(ch, rows[r].preset_val);
                    end
                end
            end
            if (rows[r].bus_load) begin
                fork
                    drive_row(rows[r]);
                    load_bus(12);
                join
            end else begin
                drive_row(rows[r]);
            end
            if (rows[r].flush) begin
                axil_write(REG_CTRL, 32'h1);
                repeat (DRAIN_IDLE) @(posedge clk);
            end else begin
                repeat (PERIOD_IDLE) @(posedge clk);   // periodic update only.
            end
            check_counters($sformatf("row %0d", r));
        end

        // a hi read after a lo read returns the hi half taken with that lo
        preset_counter(5, 64'hFFFF_FF00);
        axil_read(lo_addr(5), lo);
        check_value("snapshot lo", 64'hFFFF_FF00, lo);
        drive_row(make_row(8'h20, 1'b0, 8'd100, 3, 1'b0, 1'b0, 1'b0, 64'd0));
        axil_write(REG_CTRL, 32'h1);
        repeat (DRAIN_IDLE) @(posedge clk);
        axil_read(hi_addr(5), hi);
        check_value("snapshot hi", 64'h0, hi);

        // carry out of the low half, hi fetched without a lo read
        axil_read(hi_addr(5), hi);
        check_value("carry hi", 64'h1, hi);
        axil_read(lo_addr(5), lo);
        check_value("carry lo", 64'h2C, lo);

        axil_write(8'h08, 32'hDEAD_BEEF);
        axil_write(8'h3C, 32'h1234_5678);
        axil_write(8'h80, 32'hFFFF_FFFF);
        axil_write(8'hC4, 32'h0000_0001);
        check_counters("unmapped write");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* stat.f */
stat_pkg.sv
stat_collect.sv
stat_counter_bank.sv
stat_axil_regs.sv
stat_top.sv
stat_tb.sv
